// ==== common/pixelGenPkg.sv ====
// pixel generator shared definitions
// widths, colour layout, rectangle bounds and fade constants

`default_nettype none

package pixelGenPkg;

	// --------------------------------------------------
	// raster and colour widths
	// --------------------------------------------------
	localparam int hWidth = 11;
	localparam int vWidth = 11;
	// ARGB4444 dot, alpha in the top nibble
	localparam int dotWidth = 16;
	// RGB444 output pixel
	localparam int pixWidth = 12;
	localparam int chanWidth = 4;

	// output FIFO
	localparam int queueDepth = 16;
	localparam int queueAddrWidth = $clog2(queueDepth);

	// --------------------------------------------------
	// background rectangle, bounds inclusive
	// --------------------------------------------------
	localparam logic [hWidth-1:0] rectX0 = 11'd2;
	localparam logic [hWidth-1:0] rectX1 = 11'd5;
	localparam logic [vWidth-1:0] rectY0 = 11'd1;
	localparam logic [vWidth-1:0] rectY1 = 11'd2;
	// opaque, rgb a53
	localparam logic [dotWidth-1:0] rectColor = 16'hFA53;

	// --------------------------------------------------
	// scene fade
	// --------------------------------------------------
	localparam logic [chanWidth-1:0] fadeMax = 4'd15;
	localparam int holdWidth = 2;
	// frames spent at full alpha
	localparam logic [holdWidth-1:0] fadeHoldFrames = 2'd3;

	typedef enum logic [1:0] {fadeIdle, fadeOut, fadeHold, fadeIn} fadeState;

endpackage

`default_nettype wire

// ==== dv/tbClock.sv ====
// testbench clock and reset
// 40 ns clock, synchronous active-low reset held for 10 cycles

`timescale 1ns/1ps
`default_nettype none

module tbClock
(
	output logic iClk,
	output logic rstN
);

	localparam int halfPeriod = 20;
	localparam int resetCycles = 10;

	initial
	begin
		iClk = 1'b0;
		forever #halfPeriod iClk = ~iClk;
	end

	// released just after a rising edge, like the other inputs
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge iClk);
		#2;
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== dv/videoPixelGenTb.sv ====
// video pixel generator testbench
// drives the DUT, answers the req/ack handshake and checks every pixel
// against a raster, fade and blend model

`timescale 1ns/1ps
`default_nettype none

module videoPixelGenTb;

	localparam int hSize = 8;
	localparam int vSize = 4;
	localparam int framePixels = hSize * vSize;
	// loop limits for each wait
	localparam int waitLimit = 200;
	localparam int resetLimit = 50;
	// no acks for this long fills the queue and stalls issue
	localparam int stallCycles = 40;
	// positions issued ahead of the output once the queue is full
	localparam int queueLead = pixelGenPkg::queueDepth;

	logic iClk;
	logic rstN;
	logic [pixelGenPkg::hWidth-1:0] hDisplay;
	logic [pixelGenPkg::vWidth-1:0] vDisplay;
	logic fadeStart;
	logic [pixelGenPkg::pixWidth-1:0] sceneColor;
	logic [pixelGenPkg::pixWidth-1:0] pixel;
	logic frameStart;
	logic pixelReq;
	logic pixelAck;
	logic fadeBusy;

	int errCount = 0;
	int checkCount = 0;
	logic timedOut = 1'b0;
	// model state
	int accepted = 0;
	int sinceStart = 0;
	int fadeFrame0 = 0;
	logic fadeArmed = 1'b0;
	// handshake monitor history
	logic reqPrev = 1'b0;
	logic ackPrev = 1'b0;
	logic firstPrev = 1'b0;
	logic [pixelGenPkg::pixWidth-1:0] pixelPrev = '0;

	tbClock uClock (.iClk(iClk), .rstN(rstN));

	videoPixelGen UUT (
		.iClk(iClk), .rstN(rstN), .hDisplay(hDisplay), .vDisplay(vDisplay),
		.fadeStart(fadeStart), .sceneColor(sceneColor), .pixel(pixel),
		.frameStart(frameStart), .pixelReq(pixelReq), .pixelAck(pixelAck),
		.fadeBusy(fadeBusy)
	);

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	// frame alpha: 1..14 up, three frames at 15, 14..1 down, then 0
	function automatic int frameAlpha(input int frame);
		int d;
		if (!fadeArmed || frame < fadeFrame0)
			return 0;
		d = frame - fadeFrame0;
		if (d < 14)
			return d + 1;
		else if (d < 17)
			return 15;
		else if (d < 31)
			return 31 - d;
		return 0;
	endfunction

	// rectangle over black, scene blended on top with weight 0..16
	function automatic logic [11:0] expectPixel(input int h, input int v, input int a);
		logic [11:0] bg;
		logic [11:0] res;
		int w;
		int sum;
		bg = 12'h000;
		if (h >= int'(pixelGenPkg::rectX0) && h <= int'(pixelGenPkg::rectX1)
			&& v >= int'(pixelGenPkg::rectY0) && v <= int'(pixelGenPkg::rectY1))
			bg = 12'(pixelGenPkg::rectColor);
		w = (a < 8) ? a : a + 1;
		for (int c = 0; c < 3; c++)
		begin
			sum = int'(bg[c*4 +: 4]) * (16 - w) + int'(sceneColor[c*4 +: 4]) * w;
			res[c*4 +: 4] = 4'(sum / 16);
		end
		return res;
	endfunction

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic nextCycle;
		@(posedge iClk);
		#2;
	endtask

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errCount++;
			$display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic timeoutFail(input string what);
		errCount++;
		timedOut = 1'b1;
		$display("timeout at %0t, %s", $time, what);
	endtask

	task automatic reportTest(input int num, input string name, input int errBefore);
		$display("test %0d %s finished with %0d errors", num, name, errCount - errBefore);
	endtask

	// one four-phase transfer, pixel checked against the model
	task automatic consumePixel(input int maxDelay);
		logic [11:0] pix;
		logic [11:0] expPix;
		logic first;
		int delay;
		int n;
		int frame;
		int pos;
		n = 0;
		nextCycle;
		while (!pixelReq && n < waitLimit)
		begin
			nextCycle;
			n++;
		end
		if (!pixelReq)
		begin
			timeoutFail("pixelReq never rose");
		end
		else
		begin
			pix = pixel;
			first = frameStart;
			frame = accepted / framePixels;
			pos = accepted % framePixels;
			expPix = expectPixel(pos % hSize, pos / hSize, frameAlpha(frame));
			checkValue("frameStart", 16'(pos == 0), 16'(first));
			checkValue("pixel", 16'(expPix), 16'(pix));
			// raster size seen between start flags
			if (first && accepted > 0)
				checkValue("pixels per frame", 16'(framePixels), 16'(sinceStart));
			sinceStart = first ? 1 : sinceStart + 1;
			accepted++;
			delay = int'($urandom_range(maxDelay, 0));
			repeat (delay) nextCycle;
			pixelAck = 1'b1;
			n = 0;
			nextCycle;
			while (pixelReq && n < waitLimit)
			begin
				nextCycle;
				n++;
			end
			if (pixelReq)
				timeoutFail("pixelReq stayed high after pixelAck");
			// ack held a while after req drops, next req has to wait for it
			delay = int'($urandom_range(maxDelay, 0));
			repeat (delay) nextCycle;
			pixelAck = 1'b0;
		end
	endtask

	task automatic consumePixels(input int count, input int maxDelay);
		for (int i = 0; i < count && !timedOut; i++)
			consumePixel(maxDelay);
	endtask

	// --------------------------------------------------
	// handshake monitor, sampled mid cycle
	// --------------------------------------------------
	always @(negedge iClk)
	begin
		if (rstN)
		begin
			assert (!(pixelReq && !reqPrev && ackPrev))
			else
			begin
				errCount++;
				$display("pixelReq rose at %0t while pixelAck was still high", $time);
			end
			assert (!(pixelReq && reqPrev) || (pixel == pixelPrev && frameStart == firstPrev))
			else
			begin
				errCount++;
				$display("pixel or frameStart changed at %0t while pixelReq was high", $time);
			end
		end
		reqPrev = pixelReq;
		ackPrev = pixelAck;
		pixelPrev = pixel;
		firstPrev = frameStart;
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial
	begin
		int errBefore;
		int n;
		void'($urandom(12));
		hDisplay = 11'(hSize);
		vDisplay = 11'(vSize);
		fadeStart = 1'b0;
		sceneColor = 12'h5E7;
		pixelAck = 1'b0;

		// reset state, during reset and one cycle after
		errBefore = errCount;
		n = 0;
		@(negedge iClk);
		while (!rstN && n < resetLimit)
		begin
			checkValue("pixelReq", 16'd0, 16'(pixelReq));
			checkValue("fadeBusy", 16'd0, 16'(fadeBusy));
			@(negedge iClk);
			n++;
		end
		if (!rstN)
			timeoutFail("rstN was never released");
		checkValue("pixelReq", 16'd0, 16'(pixelReq));
		checkValue("fadeBusy", 16'd0, 16'(fadeBusy));
		reportTest(1, "reset state", errBefore);

		errBefore = errCount;
		consumePixels(framePixels, 5);
		reportTest(2, "raster order", errBefore);

		errBefore = errCount;
		consumePixels(framePixels, 5);
		reportTest(3, "background at rest", errBefore);

		// hold off acks, queue fills and issue stalls at a known count
		errBefore = errCount;
		repeat (stallCycles) nextCycle;
		fadeStart = 1'b1;
		nextCycle;
		fadeStart = 1'b0;
		// fade takes effect after the frame being issued ends
		fadeFrame0 = (accepted + queueLead) / framePixels + 1;
		fadeArmed = 1'b1;
		consumePixels((fadeFrame0 + 10) * framePixels - accepted, 5);
		checkValue("fadeBusy", 16'd1, 16'(fadeBusy));
		// second start mid fade, must be ignored
		fadeStart = 1'b1;
		nextCycle;
		fadeStart = 1'b0;
		consumePixels((fadeFrame0 + 32) * framePixels - accepted, 5);
		checkValue("fadeBusy", 16'd0, 16'(fadeBusy));
		reportTest(4, "fade sequence", errBefore);

		// slow consumer
		errBefore = errCount;
		consumePixels(2 * framePixels, 20);
		reportTest(5, "back-pressure and handshake", errBefore);

		$display("tests 5, checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/pixelGenPkg.sv
rtl/drawPosition.sv
rtl/sceneFade.sv
rtl/layerDraw.sv
pixelMerge/pixelMerge.sv
pixelMerge/pixelQueue.sv
rtl/videoPixelGen.sv
dv/tbClock.sv
dv/videoPixelGenTb.sv

// ==== pixelMerge/pixelMerge.sv ====
// dot merge stage
// alpha blends the scene dot over the opaque background dot
// and drops alpha to give one RGB444 pixel

`timescale 1ns/1ps
`default_nettype none

module pixelMerge
(
	input wire logic iClk,
	input wire logic rstN,
	input wire logic [pixelGenPkg::dotWidth-1:0] bgDot,
	input wire logic [pixelGenPkg::dotWidth-1:0] sceneDot,
	input wire logic dotValid,
	input wire logic dotFirst,
	output logic [pixelGenPkg::pixWidth-1:0] mergedPixel,
	output logic mergedValid,
	output logic mergedFirst
);

	localparam int cw = pixelGenPkg::chanWidth;

	logic [cw-1:0] sceneAlpha;
	// blend weight 0..16
	logic [cw:0] weight;
	logic [cw:0] invWeight;
	logic [pixelGenPkg::pixWidth-1:0] blended;

	// one channel: (bg * (16 - w) + scene * w) >> 4
	function automatic logic [cw-1:0] blendChan(
		input logic [cw-1:0] bg,
		input logic [cw-1:0] sc,
		input logic [cw:0] w,
		input logic [cw:0] invW
	);
		logic [2*cw:0] sum;
		sum = {{(cw+1){1'b0}}, bg} * {{cw{1'b0}}, invW}
			+ {{(cw+1){1'b0}}, sc} * {{cw{1'b0}}, w};
		return sum[2*cw-1:cw];
	endfunction

	// --------------------------------------------------
	// weight from scene alpha
	// --------------------------------------------------
	assign sceneAlpha = sceneDot[pixelGenPkg::dotWidth-1 -: cw];
	// 0..7 as is, 8..15 plus one, so 15 reaches full weight 16
	assign weight = {1'b0, sceneAlpha} + {{cw{1'b0}}, sceneAlpha[cw-1]};
	assign invWeight = 5'd16 - weight;

	// per channel blend, background alpha ignored since it is opaque
	always_comb
	begin
		for (int c = 0; c < 3; c++)
		begin
			blended[c*cw +: cw] = blendChan(bgDot[c*cw +: cw], sceneDot[c*cw +: cw],
				weight, invWeight);
		end
	end

	// pixel payload
	always_ff @(posedge iClk)
	begin
		if (dotValid)
		begin
			mergedPixel <= blended;
			mergedFirst <= dotFirst;
		end
	end

	// valid strobe, one cycle behind dotValid
	always_ff @(posedge iClk)
	begin
		if (!rstN)
			mergedValid <= 1'b0;
		else
			mergedValid <= dotValid;
	end

endmodule

`default_nettype wire

// ==== pixelMerge/pixelQueue.sv ====
// output pixel queue
// FIFO of pixel plus first-pixel flag, drained over a four-phase
// req/ack handshake, one pixel per completed transfer

`timescale 1ns/1ps
`default_nettype none

module pixelQueue
(
	input wire logic iClk,
	input wire logic rstN,
	input wire logic [pixelGenPkg::pixWidth-1:0] mergedPixel,
	input wire logic mergedValid,
	input wire logic mergedFirst,
	output logic almostFull,
	output logic [pixelGenPkg::pixWidth-1:0] pixel,
	output logic frameStart,
	output logic pixelReq,
	input wire logic pixelAck
);

	localparam int aw = pixelGenPkg::queueAddrWidth;
	localparam int ww = pixelGenPkg::pixWidth + 1;
	// room kept for the two items in the layer and merge stages
	localparam logic [aw:0] afLevel = (aw+1)'(pixelGenPkg::queueDepth - 3);

	// {first flag, pixel}
	logic [ww-1:0] mem [pixelGenPkg::queueDepth];
	logic [aw-1:0] wrPtr;
	logic [aw-1:0] rdPtr;
	logic [aw:0] count;
	logic pop;
	logic present;

	// head is popped when req drops after ack
	assign pop = pixelReq & pixelAck;
	// next transfer only once ack of the last one is low
	assign present = ~pixelReq & ~pixelAck & (count != '0);
	// fewer than 3 free entries
	assign almostFull = (count > afLevel);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (mergedValid)
			mem[wrPtr] <= {mergedFirst, mergedPixel};
	end

	// pointers and fill count
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (mergedValid)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (mergedValid && !pop)
				count <= count + 1'b1;
			else if (!mergedValid && pop)
				count <= count - 1'b1;
		end
	end

	// --------------------------------------------------
	// req/ack controller
	// --------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			pixelReq <= 1'b0;
			frameStart <= 1'b0;
		end
		else if (present)
		begin
			// head entry held stable while req is high
			pixelReq <= 1'b1;
			{frameStart, pixel} <= mem[rdPtr];
		end
		else if (pop)
		begin
			pixelReq <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/drawPosition.sv ====
// draw position counter
// scans the display in raster order, one position per allowed cycle,
// and flags the last position of each frame

`timescale 1ns/1ps
`default_nettype none

module drawPosition
(
	input wire logic iClk,
	input wire logic rstN,
	// last column and row, display size minus one
	input wire logic [pixelGenPkg::hWidth-1:0] hLast,
	input wire logic [pixelGenPkg::vWidth-1:0] vLast,
	input wire logic advance,
	output logic [pixelGenPkg::hWidth-1:0] hPos,
	output logic [pixelGenPkg::vWidth-1:0] vPos,
	output logic posValid,
	output logic frameEnd
);

	// issue starts the cycle after reset, once hLast and vLast are loaded
	logic running;
	logic lastCol;
	logic lastRow;

	// >= so a size change mid frame still wraps
	assign lastCol = (hPos >= hLast);
	assign lastRow = (vPos >= vLast);

	// the current position is issued on any enabled cycle
	assign posValid = advance & running;
	assign frameEnd = posValid & lastCol & lastRow;

	// --------------------------------------------------
	// raster step
	// --------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			running <= 1'b0;
			hPos <= '0;
			vPos <= '0;
		end
		else
		begin
			running <= 1'b1;
			if (posValid)
			begin
				if (lastCol)
				begin
					// next row, or back to 0,0 at frame end
					hPos <= '0;
					if (lastRow)
						vPos <= '0;
					else
						vPos <= vPos + 1'b1;
				end
				else
				begin
					hPos <= hPos + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/layerDraw.sv ====
// layer dot builder
// background layer: one solid rectangle over opaque black
// scene layer: a single colour with the current fade alpha

`timescale 1ns/1ps
`default_nettype none

module layerDraw
(
	input wire logic iClk,
	input wire logic rstN,
	input wire logic [pixelGenPkg::hWidth-1:0] hPos,
	input wire logic [pixelGenPkg::vWidth-1:0] vPos,
	input wire logic posValid,
	input wire logic [pixelGenPkg::chanWidth-1:0] alpha,
	input wire logic [pixelGenPkg::pixWidth-1:0] sceneColor,
	output logic [pixelGenPkg::dotWidth-1:0] bgDot,
	output logic [pixelGenPkg::dotWidth-1:0] sceneDot,
	output logic dotValid,
	output logic dotFirst
);

	// opaque black, alpha nibble full
	localparam logic [pixelGenPkg::dotWidth-1:0] blackDot = 16'hF000;

	logic inRectH;
	logic inRectV;
	logic atOrigin;

	// --------------------------------------------------
	// rectangle hit test
	// --------------------------------------------------
	assign inRectH = (hPos >= pixelGenPkg::rectX0) && (hPos <= pixelGenPkg::rectX1);
	assign inRectV = (vPos >= pixelGenPkg::rectY0) && (vPos <= pixelGenPkg::rectY1);

	// first position of the frame
	assign atOrigin = (hPos == '0) && (vPos == '0);

	// dot payload, taken only on issued positions
	always_ff @(posedge iClk)
	begin
		if (posValid)
		begin
			if (inRectH && inRectV)
				bgDot <= pixelGenPkg::rectColor;
			else
				bgDot <= blackDot;
			// alpha joined with the scene rgb
			sceneDot <= {alpha, sceneColor};
			dotFirst <= atOrigin;
		end
	end

	// valid strobe, one cycle behind posValid
	always_ff @(posedge iClk)
	begin
		if (!rstN)
			dotValid <= 1'b0;
		else
			dotValid <= posValid;
	end

endmodule

`default_nettype wire

// ==== rtl/sceneFade.sv ====
// scene fade sequencer
// steps the scene alpha once per frame: up to full, hold, then back down

`timescale 1ns/1ps
`default_nettype none

module sceneFade
(
	input wire logic iClk,
	input wire logic rstN,
	input wire logic fadeStart,
	input wire logic frameEnd,
	output logic [pixelGenPkg::chanWidth-1:0] alpha,
	output logic fadeBusy
);

	pixelGenPkg::fadeState state;
	// start request waiting for the frame boundary
	logic startPend;
	logic [pixelGenPkg::holdWidth-1:0] holdCnt;
	logic [pixelGenPkg::chanWidth-1:0] alphaUp;
	logic [pixelGenPkg::chanWidth-1:0] alphaDown;
	logic [pixelGenPkg::holdWidth-1:0] holdLast;

	assign alphaUp = alpha + 1'b1;
	assign alphaDown = alpha - 1'b1;
	assign holdLast = pixelGenPkg::fadeHoldFrames - 1'b1;

	assign fadeBusy = (state != pixelGenPkg::fadeIdle);

	// --------------------------------------------------
	// fade FSM, all changes on frameEnd
	// --------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			state <= pixelGenPkg::fadeIdle;
			alpha <= '0;
			startPend <= 1'b0;
			holdCnt <= '0;
		end
		else
		begin
			case (state)
				pixelGenPkg::fadeIdle:
				begin
					// a pulse on the boundary cycle itself counts too
					if (frameEnd && (startPend || fadeStart))
					begin
						state <= pixelGenPkg::fadeOut;
						alpha <= 4'd1;
						startPend <= 1'b0;
					end
					else if (fadeStart)
					begin
						startPend <= 1'b1;
					end
				end
				pixelGenPkg::fadeOut:
				begin
					if (frameEnd)
					begin
						alpha <= alphaUp;
						if (alphaUp == pixelGenPkg::fadeMax)
						begin
							state <= pixelGenPkg::fadeHold;
							holdCnt <= '0;
						end
					end
				end
				pixelGenPkg::fadeHold:
				begin
					// count frames at full alpha
					if (frameEnd)
					begin
						if (holdCnt == holdLast)
						begin
							state <= pixelGenPkg::fadeIn;
							alpha <= alphaDown;
						end
						else
						begin
							holdCnt <= holdCnt + 1'b1;
						end
					end
				end
				pixelGenPkg::fadeIn:
				begin
					if (frameEnd)
					begin
						alpha <= alphaDown;
						if (alphaDown == '0)
							state <= pixelGenPkg::fadeIdle;
					end
				end
				default:
				begin
					state <= pixelGenPkg::fadeIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/videoPixelGen.sv ====
// video pixel generator top
// raster counter, fade sequencer, two draw layers, merge stage
// and a req/ack output queue

`timescale 1ns/1ps
`default_nettype none

module videoPixelGen
(
	input wire logic iClk,
	input wire logic rstN,
	input wire logic [pixelGenPkg::hWidth-1:0] hDisplay,
	input wire logic [pixelGenPkg::vWidth-1:0] vDisplay,
	input wire logic fadeStart,
	input wire logic [pixelGenPkg::pixWidth-1:0] sceneColor,
	output logic [pixelGenPkg::pixWidth-1:0] pixel,
	output logic frameStart,
	output logic pixelReq,
	input wire logic pixelAck,
	output logic fadeBusy
);

	logic [pixelGenPkg::hWidth-1:0] hLast;
	logic [pixelGenPkg::vWidth-1:0] vLast;
	logic advance;
	logic [pixelGenPkg::hWidth-1:0] hPos;
	logic [pixelGenPkg::vWidth-1:0] vPos;
	logic posValid;
	logic frameEnd;
	logic [pixelGenPkg::chanWidth-1:0] alpha;
	logic [pixelGenPkg::dotWidth-1:0] bgDot;
	logic [pixelGenPkg::dotWidth-1:0] sceneDot;
	logic dotValid;
	logic dotFirst;
	logic [pixelGenPkg::pixWidth-1:0] mergedPixel;
	logic mergedValid;
	logic mergedFirst;
	logic almostFull;

	// --------------------------------------------------
	// display size register
	// --------------------------------------------------
	// counters run 0..size-1, so keep size minus one
	always_ff @(posedge iClk)
	begin
		hLast <= hDisplay - 1'b1;
		vLast <= vDisplay - 1'b1;
	end

	// stall issue while the queue is nearly full
	assign advance = ~almostFull;

	drawPosition uDrawPosition (
		.iClk(iClk), .rstN(rstN), .hLast(hLast), .vLast(vLast), .advance(advance),
		.hPos(hPos), .vPos(vPos), .posValid(posValid), .frameEnd(frameEnd)
	);

	sceneFade uSceneFade (
		.iClk(iClk), .rstN(rstN), .fadeStart(fadeStart), .frameEnd(frameEnd),
		.alpha(alpha), .fadeBusy(fadeBusy)
	);

	layerDraw uLayerDraw (
		.iClk(iClk), .rstN(rstN), .hPos(hPos), .vPos(vPos), .posValid(posValid),
		.alpha(alpha), .sceneColor(sceneColor), .bgDot(bgDot), .sceneDot(sceneDot),
		.dotValid(dotValid), .dotFirst(dotFirst)
	);

	pixelMerge uPixelMerge (
		.iClk(iClk), .rstN(rstN), .bgDot(bgDot), .sceneDot(sceneDot),
		.dotValid(dotValid), .dotFirst(dotFirst), .mergedPixel(mergedPixel),
		.mergedValid(mergedValid), .mergedFirst(mergedFirst)
	);

	// output side, four-phase handshake
	pixelQueue uPixelQueue (
		.iClk(iClk), .rstN(rstN), .mergedPixel(mergedPixel), .mergedValid(mergedValid),
		.mergedFirst(mergedFirst), .almostFull(almostFull), .pixel(pixel),
		.frameStart(frameStart), .pixelReq(pixelReq), .pixelAck(pixelAck)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/bash
# build the testbench with Verilator, run it, then scan the log for the fail message
set -o pipefail

verilator --binary --assert -f filelist.f --top-module videoPixelGenTb \
	&& ./obj_dir/VvideoPixelGenTb 2>&1 | tee sim.log \
	&& ! grep -q "TEST FAILED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
